/* logic/dds_pkg.sv */
package dds_pkg;

   ////////////////////////////////
   // widths
   ////////////////////////////////
   localparam int PHASE_W  = 32;
   localparam int SAMPLE_W = 12;
   localparam int TRACE_W  = 8;
   localparam int LFSR_W   = 5;
   localparam int KEY_COUNT = 17;

   typedef logic signed [SAMPLE_W-1:0] sample_t;   // two's complement
   typedef logic [TRACE_W-1:0]         trace_t;    // offset binary
   typedef logic [LFSR_W-1:0]          lfsr_t;
   typedef logic [KEY_COUNT-1:0]       held_keys_t;

   typedef enum logic [1:0] {
      WAVE_SAW      = 2'd0,
      WAVE_SQUARE   = 2'd1,
      WAVE_TRIANGLE = 2'd2,
      WAVE_REV_SAW  = 2'd3
   } wave_sel_e;

   typedef enum logic [1:0] {
      MOD_ASK        = 2'd0,
      MOD_MARKER     = 2'd1,
      MOD_BPSK       = 2'd2,
      MOD_LFSR_LEVEL = 2'd3
   } mod_sel_e;

   localparam sample_t SAMPLE_MAX   = 12'h7FF;
   localparam sample_t SAMPLE_MIN   = 12'h800;
   localparam sample_t MARKER_LEVEL = 12'hAA0;   // flat line on the scope
   localparam lfsr_t   LFSR_SEED    = 5'b00001;

   // key order: 1..8, F1, F2, N, M, space, left, right, up, down (bit 0)
   localparam logic [KEY_COUNT-1:0][7:0] SCAN_MAKE_CODES = {
      8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E,
      8'h05, 8'h06, 8'h31, 8'h3A, 8'h29, 8'h6B, 8'h74, 8'h75, 8'h72
   };
   // break event is the make code with bit 7 set
   localparam logic [KEY_COUNT-1:0][7:0] SCAN_BREAK_CODES = {
      8'h96, 8'h9E, 8'hA6, 8'hA5, 8'hAE, 8'hB6, 8'hBD, 8'hBE,
      8'h85, 8'h86, 8'hB1, 8'hBA, 8'hA9, 8'hEB, 8'hF4, 8'hF5, 8'hF2
   };

   // sign flip plus upper magnitude bits
   function automatic trace_t to_trace(sample_t s);
      return {~s[SAMPLE_W-1], s[SAMPLE_W-2:SAMPLE_W-TRACE_W]};
   endfunction

endpackage

/* logic/waveform_source.sv */
`timescale 1ns/1ns

module waveform_source
   import dds_pkg::*;
#(
   parameter logic [PHASE_W-1:0] PHASE_INC = 32'h0000_0102,
   parameter int                 LFSR_DIV  = 25_000_000
)
(
   input  logic      CLK_25MHZ,
   input  logic      reset_from_key,
   input  wave_sel_e wave_select,
   output sample_t   wave,
   output lfsr_t     lfsr
);

   localparam int CNT_W = (LFSR_DIV > 1) ? $clog2(LFSR_DIV) : 1;

   logic [PHASE_W-1:0]  phase;
   logic [SAMPLE_W-1:0] phase_top;
   logic [SAMPLE_W-2:0] fold;
   sample_t             saw_wave;
   sample_t             squ_wave;
   sample_t             tri_wave;
   sample_t             rev_wave;
   sample_t             sel_wave;
   logic [CNT_W-1:0]    step_cnt;
   logic                lfsr_step;

   ////////////////////////////////
   // phase accumulator
   ////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase <= '0;
      else
         phase <= phase + PHASE_INC;   // wraps freely
   end

   assign phase_top = phase[PHASE_W-1 -: SAMPLE_W];

   // second half of the cycle runs back down
   assign fold = phase_top[SAMPLE_W-1] ? ~phase_top[SAMPLE_W-2:0] : phase_top[SAMPLE_W-2:0];

   assign saw_wave = phase_top;
   assign squ_wave = phase_top[SAMPLE_W-1] ? SAMPLE_MIN : SAMPLE_MAX;
   assign tri_wave = {fold, 1'b0} ^ SAMPLE_MIN;   // recentre around zero
   assign rev_wave = ~saw_wave;

   always_comb
   begin
      case (wave_select)
         WAVE_SAW:      sel_wave = saw_wave;
         WAVE_SQUARE:   sel_wave = squ_wave;
         WAVE_TRIANGLE: sel_wave = tri_wave;
         default:       sel_wave = rev_wave;
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         wave <= '0;
      else
         wave <= sel_wave;
   end

   ////////////////////////////////
   // lfsr, slow step
   ////////////////////////////////
   assign lfsr_step = (step_cnt == CNT_W'(LFSR_DIV - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         step_cnt <= '0;
         lfsr     <= LFSR_SEED;
      end
      else if (lfsr_step)
      begin
         step_cnt <= '0;
         lfsr     <= {lfsr[LFSR_W-2:0], lfsr[4] ^ lfsr[2]};   // taps 4 and 2
      end
      else
         step_cnt <= step_cnt + 1'b1;
   end

endmodule

/* logic/display_decimator.sv */
`timescale 1ns/1ns

module display_decimator
   import dds_pkg::*;
#(
   parameter int DISPLAY_DIV = 70_000
)
(
   input  logic    CLK_25MHZ,
   input  logic    reset_from_key,
   input  sample_t wave,
   input  lfsr_t   lfsr,
   output sample_t held_wave,
   output lfsr_t   held_lfsr,
   output logic    sample_strobe
);

   localparam int CNT_W = (DISPLAY_DIV > 1) ? $clog2(DISPLAY_DIV) : 1;

   logic [CNT_W-1:0] period_cnt;
   logic             period_end;

   assign period_end = (period_cnt == CNT_W'(DISPLAY_DIV - 1));

   ////////////////////////////////
   // display rate sampling
   ////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         period_cnt    <= '0;
         sample_strobe <= 1'b0;
         held_wave     <= '0;
         held_lfsr     <= '0;
      end
      else
      begin
         sample_strobe <= period_end;   // one clock wide
         if (period_end)
         begin
            period_cnt <= '0;
            held_wave  <= wave;
            held_lfsr  <= lfsr;
         end
         else
            period_cnt <= period_cnt + 1'b1;
      end
   end

endmodule

/* logic/keying_modulator.sv */
`timescale 1ns/1ns

module keying_modulator
   import dds_pkg::*;
(
   input  logic     CLK_25MHZ,
   input  logic     reset_from_key,
   input  mod_sel_e mod_select,
   input  sample_t  held_wave,
   input  lfsr_t    held_lfsr,
   input  logic     sample_strobe,
   output sample_t  modulated,
   output trace_t   signal_trace,
   output trace_t   modulated_trace,
   output logic     trace_strobe
);

   logic    key_bit;
   sample_t keyed;

   assign key_bit = held_lfsr[0];

   ////////////////////////////////
   // keying select
   ////////////////////////////////
   always_comb
   begin
      case (mod_select)
         MOD_ASK:    keyed = key_bit ? held_wave : '0;
         MOD_MARKER: keyed = MARKER_LEVEL;
         MOD_BPSK:   keyed = key_bit ? -held_wave : held_wave;   // phase flip
         default:    keyed = key_bit ? SAMPLE_MIN : '0;          // raw lfsr level
      endcase
   end

   // outputs move only on the clock after a display sample
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         trace_strobe    <= 1'b0;
         modulated       <= '0;
         signal_trace    <= '0;
         modulated_trace <= '0;
      end
      else
      begin
         trace_strobe <= sample_strobe;
         if (sample_strobe)
         begin
            modulated       <= keyed;
            signal_trace    <= to_trace(held_wave);
            modulated_trace <= to_trace(keyed);
         end
      end
   end

endmodule

/* logic/key_tracker.sv */
`timescale 1ns/1ns

module key_tracker
   import dds_pkg::*;
(
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   input  logic       event_ready,
   input  logic [7:0] event_code,
   output held_keys_t held_keys
);

   held_keys_t make_hit;
   held_keys_t break_hit;

   ////////////////////////////////
   // table match per key
   ////////////////////////////////
   always_comb
   begin
      for (int k = 0; k < KEY_COUNT; k++)
      begin
         make_hit[k]  = (event_code == SCAN_MAKE_CODES[k]);
         break_hit[k] = (event_code == SCAN_BREAK_CODES[k]);
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         held_keys <= '0;
      else if (event_ready)
      begin
         for (int k = 0; k < KEY_COUNT; k++)
         begin
            if (make_hit[k])
               held_keys[k] <= 1'b1;
            else if (break_hit[k])
               held_keys[k] <= 1'b0;
            // unknown codes fall through, level kept
         end
      end
   end

endmodule

/* logic/dds_scope_top.sv */
`timescale 1ns/1ns

module dds_scope_top
   import dds_pkg::*;
#(
   parameter logic [PHASE_W-1:0] PHASE_INC   = 32'h0000_0102,
   parameter int                 LFSR_DIV    = 25_000_000,
   parameter int                 DISPLAY_DIV = 70_000
)
(
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   input  wave_sel_e  wave_select,
   input  mod_sel_e   mod_select,
   input  logic       event_ready,
   input  logic [7:0] event_code,
   output held_keys_t held_keys,
   output sample_t    held_signal,
   output lfsr_t      held_lfsr,
   output sample_t    modulated,
   output trace_t     signal_trace,
   output trace_t     modulated_trace,
   output logic       trace_strobe
);

   sample_t wave;            // full rate
   lfsr_t   lfsr;
   logic    sample_strobe;   // display rate

   ////////////////////////////////
   // signal chain
   ////////////////////////////////
   waveform_source #(
      .PHASE_INC (PHASE_INC),
      .LFSR_DIV  (LFSR_DIV)
   ) u_source (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .wave_select    (wave_select),
      .wave           (wave),
      .lfsr           (lfsr)
   );

   display_decimator #(
      .DISPLAY_DIV (DISPLAY_DIV)
   ) u_decimator (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .wave           (wave),
      .lfsr           (lfsr),
      .held_wave      (held_signal),
      .held_lfsr      (held_lfsr),
      .sample_strobe  (sample_strobe)
   );

   keying_modulator u_modulator (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .mod_select      (mod_select),
      .held_wave       (held_signal),
      .held_lfsr       (held_lfsr),
      .sample_strobe   (sample_strobe),
      .modulated       (modulated),
      .signal_trace    (signal_trace),
      .modulated_trace (modulated_trace),
      .trace_strobe    (trace_strobe)
   );

   ////////////////////////////////
   // keyboard levels
   ////////////////////////////////
   key_tracker u_keys (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .event_ready    (event_ready),
      .event_code     (event_code),
      .held_keys      (held_keys)
   );

endmodule

/* bench/dds_scope_assert.sv */
`timescale 1ns/1ns

module dds_scope_assert
   import dds_pkg::*;
(
   input logic       CLK_25MHZ,
   input logic       reset_from_key,
   input wave_sel_e  wave_select,
   input mod_sel_e   mod_select,
   input logic       event_ready,
   input logic [7:0] event_code,
   input held_keys_t held_keys,
   input sample_t    held_signal,
   input lfsr_t      held_lfsr,
   input sample_t    modulated,
   input trace_t     signal_trace,
   input trace_t     modulated_trace,
   input logic       trace_strobe
);

   logic        error_seen = 1'b0;   // polled by the testbench
   wave_sel_e   sel_d;
   logic [3:0]  same_run;            // clocks with an unchanged wave_select
   mod_sel_e    mod_d;
   logic        prev_valid;
   sample_t     prev_signal;
   lfsr_t       prev_lfsr;
   logic        keys_valid;
   logic        ev_ready_d;
   logic [7:0]  ev_code_d;
   held_keys_t  keys_d;
   held_keys_t  keys_expect;
   sample_t     keyed_expect;
   logic [11:0] saw_step;
   lfsr_t       lfsr_next;
   trace_t      sig_trace_expect;
   trace_t      mod_trace_expect;

   ////////////////////////////////
   // history of the last clocks
   ////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      sel_d      <= wave_select;
      mod_d      <= mod_select;   // mode seen by the modulator register
      ev_ready_d <= event_ready;
      ev_code_d  <= event_code;
      keys_d     <= held_keys;
      keys_valid <= !reset_from_key;
      if (reset_from_key)
      begin
         same_run    <= '0;
         prev_valid  <= 1'b0;
         prev_signal <= '0;
         prev_lfsr   <= '0;
      end
      else
      begin
         if (wave_select != sel_d)
            same_run <= '0;
         else if (same_run != 4'd15)
            same_run <= same_run + 1'b1;
         if (trace_strobe)
         begin
            prev_valid  <= 1'b1;
            prev_signal <= held_signal;
            prev_lfsr   <= held_lfsr;
         end
      end
   end

   assign saw_step         = held_signal - prev_signal;   // modulo 4096
   assign lfsr_next        = {prev_lfsr[3:0], prev_lfsr[4] ^ prev_lfsr[2]};
   assign sig_trace_expect = {~held_signal[11], held_signal[10:4]};
   assign mod_trace_expect = {~modulated[11], modulated[10:4]};

   always_comb
   begin
      case (mod_d)
         MOD_ASK:    keyed_expect = held_lfsr[0] ? held_signal : 12'h000;
         MOD_MARKER: keyed_expect = 12'hAA0;
         MOD_BPSK:   keyed_expect = held_lfsr[0] ? 12'(~held_signal + 1'b1) : held_signal;
         default:    keyed_expect = held_lfsr[0] ? 12'h800 : 12'h000;
      endcase
   end

   // make sets, break clears, the rest keeps the old level
   always_comb
   begin
      keys_expect = keys_d;
      if (ev_ready_d)
      begin
         for (int k = 0; k < KEY_COUNT; k++)
         begin
            if (ev_code_d == SCAN_MAKE_CODES[k])
               keys_expect[k] = 1'b1;
            else if (ev_code_d == SCAN_BREAK_CODES[k])
               keys_expect[k] = 1'b0;
         end
      end
   end

   ////////////////////////////////
   // checks
   ////////////////////////////////
   a_reset: assert property (@(posedge CLK_25MHZ) reset_from_key |=>
      (!trace_strobe && held_keys == '0 && held_lfsr == '0))
   else
   begin
      $error("ERR reset expected strobe 0 keys 00000 lfsr 00 actual strobe %b keys %h lfsr %h",
         $sampled(trace_strobe), $sampled(held_keys), $sampled(held_lfsr));
      error_seen = 1'b1;
   end

   a_saw_step: assert property (@(posedge CLK_25MHZ)
      trace_strobe && prev_valid && same_run >= 4'd7 && sel_d == WAVE_SAW |->
      saw_step == 12'd15)
   else
   begin
      $error("ERR saw_step expected %0d actual %0d", 15, $sampled(saw_step));
      error_seen = 1'b1;
   end

   a_lfsr_step: assert property (@(posedge CLK_25MHZ) trace_strobe && prev_valid |->
      held_lfsr == prev_lfsr || held_lfsr == lfsr_next)
   else
   begin
      $error("ERR lfsr_step expected %h or %h actual %h",
         $sampled(prev_lfsr), $sampled(lfsr_next), $sampled(held_lfsr));
      error_seen = 1'b1;
   end

   a_lfsr_nonzero: assert property (@(posedge CLK_25MHZ) trace_strobe |-> held_lfsr != '0)
   else
   begin
      $error("ERR lfsr_nonzero expected nonzero actual %h", $sampled(held_lfsr));
      error_seen = 1'b1;
   end

   a_keying: assert property (@(posedge CLK_25MHZ) trace_strobe |-> modulated == keyed_expect)
   else
   begin
      $error("ERR keying expected %h actual %h", $sampled(keyed_expect), $sampled(modulated));
      error_seen = 1'b1;
   end

   a_signal_trace: assert property (@(posedge CLK_25MHZ) trace_strobe |->
      signal_trace == sig_trace_expect)
   else
   begin
      $error("ERR signal_trace expected %h actual %h",
         $sampled(sig_trace_expect), $sampled(signal_trace));
      error_seen = 1'b1;
   end

   a_mod_trace: assert property (@(posedge CLK_25MHZ) trace_strobe |->
      modulated_trace == mod_trace_expect)
   else
   begin
      $error("ERR modulated_trace expected %h actual %h",
         $sampled(mod_trace_expect), $sampled(modulated_trace));
      error_seen = 1'b1;
   end

   a_square_level: assert property (@(posedge CLK_25MHZ)
      trace_strobe && same_run >= 4'd7 && sel_d == WAVE_SQUARE |->
      held_signal == 12'h7FF || held_signal == 12'h800)
   else
   begin
      $error("ERR square_level expected 7ff or 800 actual %h", $sampled(held_signal));
      error_seen = 1'b1;
   end

   a_held_keys: assert property (@(posedge CLK_25MHZ) keys_valid |-> held_keys == keys_expect)
   else
   begin
      $error("ERR held_keys expected %h actual %h", $sampled(keys_expect), $sampled(held_keys));
      error_seen = 1'b1;
   end

endmodule

bind dds_scope_top dds_scope_assert u_assert (
   .CLK_25MHZ       (CLK_25MHZ),
   .reset_from_key  (reset_from_key),
   .wave_select     (wave_select),
   .mod_select      (mod_select),
   .event_ready     (event_ready),
   .event_code      (event_code),
   .held_keys       (held_keys),
   .held_signal     (held_signal),
   .held_lfsr       (held_lfsr),
   .modulated       (modulated),
   .signal_trace    (signal_trace),
   .modulated_trace (modulated_trace),
   .trace_strobe    (trace_strobe)
);

/* bench/tb_dds_scope.sv */
`timescale 1ns/1ns

module tb_dds_scope
   import dds_pkg::*;
();

   localparam logic [31:0] PHASE_INC        = 32'h0030_0000;
   localparam int          LFSR_DIV         = 8;
   localparam int          DISPLAY_DIV      = 5;
   localparam int          TRACE_LIMIT      = 4 * DISPLAY_DIV;   // cycles per strobe wait
   localparam int          SAMPLES_PER_MODE = 6;
   localparam int          EVENT_COUNT      = 80;
   localparam logic [31:0] SEED             = 32'heee6_c14b;

   // codes in neither table
   localparam logic [3:0][7:0] UNKNOWN_CODES = {8'h00, 8'h12, 8'hE0, 8'hF0};

   logic       CLK_25MHZ;
   logic       reset_from_key;
   wave_sel_e  wave_select;
   mod_sel_e   mod_select;
   logic       event_ready;
   logic [7:0] event_code;
   held_keys_t held_keys;
   sample_t    held_signal;
   lfsr_t      held_lfsr;
   sample_t    modulated;
   trace_t     signal_trace;
   trace_t     modulated_trace;
   logic       trace_strobe;

   dds_scope_top #(
      .PHASE_INC   (PHASE_INC),
      .LFSR_DIV    (LFSR_DIV),
      .DISPLAY_DIV (DISPLAY_DIV)
   ) u_dut (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .wave_select     (wave_select),
      .mod_select      (mod_select),
      .event_ready     (event_ready),
      .event_code      (event_code),
      .held_keys       (held_keys),
      .held_signal     (held_signal),
      .held_lfsr       (held_lfsr),
      .modulated       (modulated),
      .signal_trace    (signal_trace),
      .modulated_trace (modulated_trace),
      .trace_strobe    (trace_strobe)
   );

   always #20 CLK_25MHZ = ~CLK_25MHZ;   // 40 ns period

   task automatic fail_run(input string why);
      $display("TESTS FAILED");
      $fatal(1, "%s", why);
   endtask

   task automatic next_drive_point();
      @(posedge CLK_25MHZ);
      #2;
   endtask

   // returns on the falling edge inside the strobe cycle
   task automatic wait_for_trace(input string what);
      int cycles;
      cycles = 0;
      @(negedge CLK_25MHZ);
      while (trace_strobe !== 1'b1)
      begin
         if (cycles == TRACE_LIMIT)
            fail_run($sformatf("timeout: no trace_strobe during %s", what));
         @(negedge CLK_25MHZ);
         cycles++;
      end
   endtask

   always @(posedge CLK_25MHZ)
   begin
      if (u_dut.u_assert.error_seen)
         fail_run("an assertion check failed, see the ERR line above");
   end

   initial
   begin
      int         k;
      int         kind;
      logic [7:0] code;
      CLK_25MHZ      = 1'b0;
      reset_from_key = 1'b1;
      wave_select    = WAVE_SAW;
      mod_select     = MOD_ASK;
      event_ready    = 1'b0;
      event_code     = 8'h00;
      void'($urandom(SEED));
      repeat (4) @(posedge CLK_25MHZ);
      #2;
      reset_from_key = 1'b0;

      ////////////////////////////////
      // every wave against every keying
      ////////////////////////////////
      for (int w = 0; w < 4; w++)
      begin
         next_drive_point();
         wave_select = wave_sel_e'(w);
         for (int m = 0; m < 4; m++)
         begin
            next_drive_point();
            mod_select = mod_sel_e'(m);
            repeat (SAMPLES_PER_MODE)
               wait_for_trace($sformatf("wave %0d keying %0d", w, m));
         end
      end

      ////////////////////////////////
      // random key events
      ////////////////////////////////
      for (int i = 0; i < EVENT_COUNT; i++)
      begin
         k    = $urandom_range(KEY_COUNT - 1, 0);
         kind = $urandom_range(3, 0);
         case (kind)
            0, 1:    code = SCAN_MAKE_CODES[k];   // presses a bit more often
            2:       code = SCAN_BREAK_CODES[k];
            default: code = UNKNOWN_CODES[k % 4];
         endcase
         next_drive_point();
         event_ready = ($urandom_range(4, 0) != 0);   // sometimes a code without ready
         event_code  = code;
      end
      next_drive_point();
      event_ready = 1'b0;

      repeat (3) @(posedge CLK_25MHZ);
      @(negedge CLK_25MHZ);
      if (u_dut.u_assert.error_seen)
         fail_run("an assertion check failed near the end of the run");
      else
      begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule

/* project.f */
logic/dds_pkg.sv
logic/waveform_source.sv
logic/display_decimator.sv
logic/keying_modulator.sv
logic/key_tracker.sv
logic/dds_scope_top.sv
bench/dds_scope_assert.sv
bench/tb_dds_scope.sv

/* Bender.yml */
package:
  name: dds_scope

sources:
  - logic/dds_pkg.sv
  - logic/waveform_source.sv
  - logic/display_decimator.sv
  - logic/keying_modulator.sv
  - logic/key_tracker.sv
  - logic/dds_scope_top.sv
  - target: test
    files:
      - bench/dds_scope_assert.sv
      - bench/tb_dds_scope.sv
